// File: all.f
cpu_clk_pkg.sv
cpu_irq_pkg.sv
cpu_reset_ctrl.sv
cpu_wake_ctrl.sv
cpu_unit_clk_ctrl.sv
cpu_tcm_lp_ctrl.sv
cpu_aon_top.sv
tb_cpu_aon.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the always-on testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu_aon -f all.f > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_cpu_aon > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

// File: tb_cpu_aon.sv
// Self-checking testbench for the always-on glue of the core.
// Drives reset, interrupts, wfi and unit activity on the falling edge and
// checks every output after each rising edge against a cycle model.

`timescale 1ns/1ps

module tb_cpu_aon;

  localparam int UNITS    = cpu_clk_pkg::NUM_UNITS;
  localparam int HOLD     = cpu_clk_pkg::CLK_HOLD_CYCLES;
  localparam int LS_IDLE  = cpu_clk_pkg::LS_ENTRY_CYCLES;
  localparam int RST_SYNC = cpu_clk_pkg::RST_SYNC_STAGES;
  localparam int IRQ_SYNC = cpu_irq_pkg::IRQ_SYNC_STAGES;

  logic                    clk;
  logic                    arst_n;
  logic                    test_mode;
  logic                    core_cgstop;
  cpu_clk_pkg::unit_vec_t  unit_active;
  logic                    wfi_req;
  cpu_irq_pkg::irq_lines_t irq_a;
  logic                    rst_aon_n;
  logic                    rst_core_n;
  cpu_irq_pkg::irq_lines_t irq_r;
  logic                    core_wfi;
  cpu_clk_pkg::unit_vec_t  unit_clk;
  cpu_clk_pkg::unit_vec_t  unit_clk_en;
  logic                    tcm_ls;

  // Cycle model
  int                      rel_edges;  // Edges seen with arst_n high
  cpu_irq_pkg::irq_lines_t m_irq_d1;
  cpu_irq_pkg::irq_lines_t m_irq_d2;   // irq_a two edges back
  logic                    m_sleep;
  int                      m_hold [UNITS];
  cpu_clk_pkg::unit_vec_t  m_en;
  int                      m_idle;
  logic                    m_ls;

  int                      pulse_cnt [UNITS];
  int                      pulse_seen [UNITS];
  cpu_clk_pkg::unit_vec_t  clk_prev;
  logic [31:0]             lfsr_q = 32'hbde026f6;
  int                      mismatch_cnt;
  int                      other_cnt;

  cpu_aon_top uut (
    .clk         (clk        ),
    .arst_n      (arst_n     ),
    .test_mode   (test_mode  ),
    .core_cgstop (core_cgstop),
    .unit_active (unit_active),
    .wfi_req     (wfi_req    ),
    .irq_a       (irq_a      ),
    .rst_aon_n   (rst_aon_n  ),
    .rst_core_n  (rst_core_n ),
    .irq_r       (irq_r      ),
    .core_wfi    (core_wfi   ),
    .unit_clk    (unit_clk   ),
    .unit_clk_en (unit_clk_en),
    .tcm_ls      (tcm_ls     )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random bits and reference rules

  // Taps 32, 22, 2, 1
  function automatic logic rand_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [3:0] rand_nibble();
    logic [3:0] v;
    for (int i = 0; i < 4; i++) begin
      v[2'(i)] = rand_bit();
    end
    return v;
  endfunction

  function automatic int hold_next(logic active, int hold);
    if (active) return HOLD;
    return (hold > 0) ? hold - 1 : 0;
  endfunction

  function automatic logic enable_next(logic active, int hold, logic sleep,
                                       logic cgstop, logic tm);
    return cgstop || tm || ((active || hold != 0) && !sleep);
  endfunction

  function automatic logic sleep_next(logic sleep, logic wfi, logic pend);
    if (!sleep) return wfi && !pend;
    return !pend;  // Any synced line wakes
  endfunction

  function automatic int idle_count_next(int cnt, logic idle);
    if (!idle) return 0;
    return (cnt >= LS_IDLE) ? LS_IDLE : cnt + 1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Model step and compare

  function automatic void check_value(string name, int got, int exp);
    if (got != exp) begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      mismatch_cnt++;
    end
  endfunction

  // One rising edge, from pre-edge inputs and model state
  function automatic void step_model();
    logic                   pre_aon;
    logic                   pre_core;
    logic                   pre_sleep;
    logic                   pre_pend;
    cpu_clk_pkg::unit_vec_t pre_en;
    pre_aon   = arst_n && (test_mode || rel_edges >= RST_SYNC);
    pre_core  = arst_n && (test_mode || rel_edges > RST_SYNC);
    pre_sleep = m_sleep;
    pre_pend  = (int'(m_irq_d2) != 0);
    pre_en    = m_en;
    if (!arst_n) rel_edges = 0;
    else if (rel_edges < 16) rel_edges++;
    if (!pre_aon) begin
      m_irq_d1 = '0;
      m_irq_d2 = '0;
      m_sleep  = 1'b0;
      m_idle   = 0;
      m_ls     = 1'b0;
    end else begin
      m_sleep  = sleep_next(pre_sleep, wfi_req, pre_pend);
      m_irq_d2 = m_irq_d1;
      m_irq_d1 = irq_a;
      m_idle   = idle_count_next(m_idle, !pre_en[cpu_clk_pkg::UNIT_IFU] &&
                                         !pre_en[cpu_clk_pkg::UNIT_LSU]);
      m_ls     = (m_idle == LS_IDLE);
    end
    for (int i = 0; i < UNITS; i++) begin
      if (!pre_core) begin
        m_hold[2'(i)] = 0;
        m_en[2'(i)]   = 1'b0;
      end else begin
        m_en[2'(i)]   = enable_next(unit_active[2'(i)], m_hold[2'(i)], pre_sleep,
                                    core_cgstop, test_mode);
        m_hold[2'(i)] = hold_next(unit_active[2'(i)], m_hold[2'(i)]);
      end
    end
  endfunction

  function automatic void compare_outputs();
    logic exp_aon;
    logic exp_core;
    int   pulses;
    exp_aon  = arst_n && (test_mode || rel_edges >= RST_SYNC);
    exp_core = arst_n && (test_mode || rel_edges > RST_SYNC);
    check_value("rst_aon_n", int'(rst_aon_n), int'(exp_aon));
    check_value("rst_core_n", int'(rst_core_n), int'(exp_core));
    check_value("irq_r", int'(irq_r), int'(m_irq_d2));
    check_value("core_wfi", int'(core_wfi), int'(m_sleep));
    check_value("unit_clk_en", int'(unit_clk_en), int'(m_en));
    check_value("tcm_ls", int'(tcm_ls), int'(m_ls));
    for (int i = 0; i < UNITS; i++) begin
      pulses            = pulse_cnt[2'(i)] - pulse_seen[2'(i)];
      pulse_seen[2'(i)] = pulse_cnt[2'(i)];
      check_value($sformatf("unit_clk[%0d] rising edges", i), pulses, int'(m_en[2'(i)]));
    end
  endfunction

  // Rising edges of each gated clock
  always @(unit_clk) begin
    for (int i = 0; i < UNITS; i++) begin
      if (unit_clk[2'(i)] && !clk_prev[2'(i)]) pulse_cnt[2'(i)]++;
    end
    clk_prev = unit_clk;
  end

  initial begin : compare_proc
    forever begin
      @(posedge clk);
      step_model();
      #1;
      compare_outputs();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus sequences

  task automatic pulse_wfi();
    @(negedge clk);
    wfi_req = 1'b1;
    @(negedge clk);
    wfi_req = 1'b0;
  endtask

  task automatic wait_irq_quiet();
    int n;
    n = 0;
    while (int'(irq_r) != 0 && n < 8) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (int'(irq_r) != 0) begin
      $display("Timed out waiting for irq_r to clear at %0t", $time);
      other_cnt++;
    end
  endtask

  task automatic release_from_reset();
    int n;
    int aon_at;
    int core_at;
    repeat (8) @(negedge clk);
    arst_n  = 1'b1;
    n       = 0;
    aon_at  = 0;
    core_at = 0;
    while (core_at == 0 && n < 16) begin
      @(posedge clk);
      #1;
      n++;
      if (rst_aon_n && aon_at == 0) aon_at = n;
      if (rst_core_n) core_at = n;
    end
    if (core_at == 0) begin
      $display("Timed out waiting for rst_core_n to rise at %0t", $time);
      other_cnt++;
    end else begin
      check_value("rst_aon_n release edge", aon_at, RST_SYNC);
      check_value("rst_core_n release edge", core_at, RST_SYNC + 1);
    end
  endtask

  // Both resets follow the pin with no edge in between
  task automatic pulse_reset_in_test_mode();
    @(negedge clk);
    test_mode = 1'b1;
    @(negedge clk);
    arst_n = 1'b0;
    #1;
    check_value("rst_aon_n in test mode", int'(rst_aon_n), 0);
    check_value("rst_core_n in test mode", int'(rst_core_n), 0);
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    #1;
    check_value("rst_aon_n in test mode", int'(rst_aon_n), 1);
    check_value("rst_core_n in test mode", int'(rst_core_n), 1);
    repeat (4) @(negedge clk);
    test_mode = 1'b0;
  endtask

  task automatic drive_random_irqs();
    repeat (100) begin
      @(negedge clk);
      irq_a = rand_nibble();
    end
    @(negedge clk);
    irq_a = '0;
  endtask

  // Sparse activity, rare cgstop, wfi and wake lines all mixed
  task automatic exercise_clock_gating();
    repeat (300) begin
      @(negedge clk);
      unit_active = rand_nibble() & rand_nibble();
      core_cgstop = rand_bit() & rand_bit() & rand_bit();
      wfi_req     = rand_bit() & rand_bit() & rand_bit();
      irq_a       = rand_nibble() & rand_nibble() & rand_nibble();
    end
    @(negedge clk);
    core_cgstop = 1'b0;
    wfi_req     = 1'b0;
    irq_a       = '0;
  endtask

  task automatic sleep_and_wake();
    int         n;
    logic [1:0] line;
    @(negedge clk);
    unit_active = 4'hf;
    wait_irq_quiet();
    pulse_wfi();
    if (!core_wfi) begin
      $display("core_wfi did not rise after wfi_req with no interrupt at %0t", $time);
      other_cnt++;
    end
    @(negedge clk);
    check_value("unit_clk_en in sleep", int'(unit_clk_en), 0);
    core_cgstop = 1'b1;
    @(negedge clk);
    check_value("unit_clk_en in sleep with cgstop", int'(unit_clk_en), 15);
    core_cgstop = 1'b0;
    line  = {rand_bit(), rand_bit()};
    irq_a = 4'b0001 << line;
    n     = 0;
    while (core_wfi && n < 8) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (core_wfi) begin
      $display("Timed out waiting for the interrupt to wake the core at %0t", $time);
      other_cnt++;
    end else begin
      check_value("wake edges", n, IRQ_SYNC + 1);
    end
    pulse_wfi();  // Line still pending here
    if (core_wfi) begin
      $display("core_wfi rose on a wfi_req with irq_r pending at %0t", $time);
      other_cnt++;
    end
    @(negedge clk);
    irq_a = '0;
    wait_irq_quiet();
  endtask

  task automatic enter_light_sleep();
    int n;
    @(negedge clk);
    unit_active = 4'hf;
    repeat (3) @(negedge clk);
    unit_active = '0;
    unit_active[cpu_clk_pkg::UNIT_EXU] = 1'b1;
    unit_active[cpu_clk_pkg::UNIT_BIU] = 1'b1;
    n = 0;
    while (!tcm_ls && n < 32) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!tcm_ls) begin
      $display("Timed out waiting for tcm_ls with fetch and load-store idle at %0t", $time);
      other_cnt++;
    end else begin
      check_value("tcm_ls entry edges", n, HOLD + 1 + LS_IDLE);
    end
    @(negedge clk);
    unit_active[cpu_clk_pkg::UNIT_LSU] = 1'b1;
    n = 0;
    while (tcm_ls && n < 8) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (tcm_ls) begin
      $display("Timed out waiting for tcm_ls to fall at %0t", $time);
      other_cnt++;
    end else begin
      check_value("tcm_ls exit edges", n, 2);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    arst_n       = 1'b0;
    test_mode    = 1'b0;
    core_cgstop  = 1'b0;
    unit_active  = '0;
    wfi_req      = 1'b0;
    irq_a        = '0;
    rel_edges    = 0;
    m_irq_d1     = '0;
    m_irq_d2     = '0;
    m_sleep      = 1'b0;
    m_en         = '0;
    m_idle       = 0;
    m_ls         = 1'b0;
    clk_prev     = '0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    release_from_reset();
    pulse_reset_in_test_mode();
    drive_random_irqs();
    exercise_clock_gating();
    sleep_and_wake();
    enter_light_sleep();
    repeat (4) @(negedge clk);
    $display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: cpu_aon_top.sv
// Always-on glue of the core.
// Ties together reset release, interrupt sync with wfi sleep, one clock
// gate per core unit and the TCM light-sleep request.

`timescale 1ns/1ps

module cpu_aon_top (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    test_mode,
  input  logic                    core_cgstop,
  input  cpu_clk_pkg::unit_vec_t  unit_active,
  input  logic                    wfi_req,
  input  cpu_irq_pkg::irq_lines_t irq_a,
  output logic                    rst_aon_n,
  output logic                    rst_core_n,
  output cpu_irq_pkg::irq_lines_t irq_r,
  output logic                    core_wfi,
  output cpu_clk_pkg::unit_vec_t  unit_clk,
  output cpu_clk_pkg::unit_vec_t  unit_clk_en,
  output logic                    tcm_ls
);

  //////////////////////////////////////////////////////////////////////
  // Reset and wake

  cpu_reset_ctrl u_reset_ctrl (
    .clk        (clk       ),
    .arst_n     (arst_n    ),
    .test_mode  (test_mode ),
    .rst_aon_n  (rst_aon_n ),
    .rst_core_n (rst_core_n)
  );

  cpu_wake_ctrl u_wake_ctrl (
    .clk      (clk      ),
    .rst_n    (rst_aon_n),  // Must keep running while the core sleeps
    .irq_a    (irq_a    ),
    .wfi_req  (wfi_req  ),
    .irq_r    (irq_r    ),
    .core_wfi (core_wfi )
  );

  //////////////////////////////////////////////////////////////////////
  // Unit clock gates, indexed by unit_e

  for (genvar i = 0; i < cpu_clk_pkg::NUM_UNITS; i++) begin : g_unit
    cpu_unit_clk_ctrl u_unit_clk_ctrl (
      .clk       (clk           ),
      .rst_n     (rst_core_n    ),
      .active    (unit_active[i]),
      .core_wfi  (core_wfi      ),
      .cgstop    (core_cgstop   ),
      .test_mode (test_mode     ),
      .clk_en    (unit_clk_en[i]),
      .gated_clk (unit_clk[i]   )
    );
  end

  //////////////////////////////////////////////////////////////////////
  // TCM light sleep

  cpu_tcm_lp_ctrl u_tcm_lp_ctrl (
    .clk         (clk        ),
    .rst_n       (rst_aon_n  ),
    .unit_clk_en (unit_clk_en),
    .tcm_ls      (tcm_ls     )
  );

endmodule

// File: cpu_tcm_lp_ctrl.sv
// Light-sleep controller for the tightly-coupled memories.
// Counts edges with both the fetch and load-store clocks closed and
// requests memory light sleep once the count reaches the entry limit.

`timescale 1ns/1ps

module cpu_tcm_lp_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_clk_pkg::unit_vec_t unit_clk_en,
  output logic                   tcm_ls
);

  localparam cpu_clk_pkg::ls_cnt_t ENTRY =
    cpu_clk_pkg::ls_cnt_t'(cpu_clk_pkg::LS_ENTRY_CYCLES);

  logic                 ifu_en;
  logic                 lsu_en;
  logic                 tcm_idle;
  cpu_clk_pkg::ls_cnt_t ls_cnt_q;
  cpu_clk_pkg::ls_cnt_t ls_cnt_nxt;

  assign ifu_en   = unit_clk_en[cpu_clk_pkg::UNIT_IFU];
  assign lsu_en   = unit_clk_en[cpu_clk_pkg::UNIT_LSU];
  assign tcm_idle = !ifu_en && !lsu_en;  // Only these two reach the TCMs

  //////////////////////////////////////////////////////////////////////
  // Idle counter, saturating at the entry count

  always_comb begin
    if (!tcm_idle) begin
      ls_cnt_nxt = '0;
    end else if (ls_cnt_q == ENTRY) begin
      ls_cnt_nxt = ls_cnt_q;
    end else begin
      ls_cnt_nxt = ls_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ls_cnt_q <= '0;
      tcm_ls   <= 1'b0;
    end else begin
      ls_cnt_q <= ls_cnt_nxt;
      tcm_ls   <= (ls_cnt_nxt == ENTRY);  // Drops with the first wake edge
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks

  a_ls_needs_idle : assert property (
    @(posedge clk) disable iff (!rst_n)
    tcm_ls |-> $past(tcm_idle)
  ) else $error("tcm_ls high after a fetch or load-store clock edge");

endmodule

// File: cpu_unit_clk_ctrl.sv
// Clock controller for one core unit.
// Keeps the unit clock open while the unit is active and for a short
// hold tail after, closes it during wfi sleep unless cgstop or test mode.

`timescale 1ns/1ps

module cpu_unit_clk_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic active,
  input  logic core_wfi,
  input  logic cgstop,
  input  logic test_mode,
  output logic clk_en,
  output logic gated_clk
);

  cpu_clk_pkg::hold_cnt_t hold_cnt_q;
  logic                   hold_busy;
  logic                   en_nxt;
  logic                   en_lat;

  assign hold_busy = (hold_cnt_q != '0);

  //////////////////////////////////////////////////////////////////////
  // Activity hold counter

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_cnt_q <= '0;
    end else if (active) begin
      hold_cnt_q <= cpu_clk_pkg::hold_cnt_t'(cpu_clk_pkg::CLK_HOLD_CYCLES);
    end else if (hold_busy) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;  // Count down the tail
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Enable register and clock gate

  // Overrides first, then activity unless the core sleeps
  assign en_nxt = cgstop || test_mode || ((active || hold_busy) && !core_wfi);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clk_en <= 1'b0;
    end else begin
      clk_en <= en_nxt;
    end
  end

  // Latch follows the next enable through the low phase, so the high
  // phase after an edge matches the clk_en taken at that edge
  always_latch begin
    if (!rst_n) begin
      en_lat = 1'b0;
    end else if (!clk) begin
      en_lat = en_nxt;
    end
  end

  assign gated_clk = clk && en_lat;

  //////////////////////////////////////////////////////////////////////
  // Checks

  a_cgstop_opens : assert property (
    @(posedge clk) disable iff (!rst_n)
    cgstop |=> clk_en
  ) else $error("unit clock closed while cgstop was high");

endmodule

// File: cpu_wake_ctrl.sv
// Wake controller of the always-on domain.
// Synchronizes the asynchronous interrupt lines and runs the
// wait-for-interrupt state; core_wfi is high while the core sleeps.

`timescale 1ns/1ps

module cpu_wake_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cpu_irq_pkg::irq_lines_t irq_a,
  input  logic                    wfi_req,
  output cpu_irq_pkg::irq_lines_t irq_r,
  output logic                    core_wfi
);

  localparam int LINES  = cpu_irq_pkg::IRQ_LINES;
  localparam int STAGES = cpu_irq_pkg::IRQ_SYNC_STAGES;

  logic [LINES-1:0]         irq_a_vec;
  logic [LINES-1:0]         irq_r_vec;
  logic                     irq_pend;   // Any synchronized line high
  cpu_irq_pkg::wake_state_e state_q;
  cpu_irq_pkg::wake_state_e state_nxt;

  assign irq_a_vec = irq_a;

  //////////////////////////////////////////////////////////////////////
  // Synchronizer chains, one per line

  for (genvar i = 0; i < LINES; i++) begin : g_sync
    logic [STAGES-1:0] sync_q;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        sync_q <= '0;
      end else begin
        sync_q <= {sync_q[STAGES-2:0], irq_a_vec[i]};
      end
    end

    assign irq_r_vec[i] = sync_q[STAGES-1];
  end

  assign irq_r    = irq_r_vec;
  assign irq_pend = |irq_r_vec;

  //////////////////////////////////////////////////////////////////////
  // Run/sleep state

  always_comb begin
    state_nxt = state_q;
    unique case (state_q)
      cpu_irq_pkg::WAKE_RUN: begin
        // A pending line cancels the wfi request
        if (wfi_req && !irq_pend) begin
          state_nxt = cpu_irq_pkg::WAKE_SLEEP;
        end
      end
      cpu_irq_pkg::WAKE_SLEEP: begin
        if (irq_pend) begin
          state_nxt = cpu_irq_pkg::WAKE_RUN;  // Any line wakes the core
        end
      end
      default: state_nxt = cpu_irq_pkg::WAKE_RUN;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= cpu_irq_pkg::WAKE_RUN;
    end else begin
      state_q <= state_nxt;
    end
  end

  assign core_wfi = (state_q == cpu_irq_pkg::WAKE_SLEEP);

  //////////////////////////////////////////////////////////////////////
  // Checks

  // Sleep only ever starts from a quiet interrupt state
  a_no_sleep_on_irq : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(core_wfi) |-> ($past(irq_r_vec) == '0)
  ) else $error("core_wfi rose with an interrupt pending");

endmodule

// File: cpu_reset_ctrl.sv
// Reset controller of the always-on domain.
// Asserts both resets at once and releases the always-on reset after the
// sync chain, the core reset one edge later. Test mode passes arst_n through.

`timescale 1ns/1ps

module cpu_reset_ctrl (
  input  logic clk,
  input  logic arst_n,
  input  logic test_mode,
  output logic rst_aon_n,
  output logic rst_core_n
);

  localparam int STAGES = cpu_clk_pkg::RST_SYNC_STAGES;

  logic [STAGES-1:0] aon_sync_q;   // Release chain for the always-on reset
  logic              core_sync_q;  // Extra stage for the core

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      aon_sync_q  <= '0;
      core_sync_q <= 1'b0;
    end else begin
      aon_sync_q  <= {aon_sync_q[STAGES-2:0], 1'b1};
      core_sync_q <= aon_sync_q[STAGES-1];
    end
  end

  // Scan needs the pin in direct control of every flop
  assign rst_aon_n  = test_mode ? arst_n : aon_sync_q[STAGES-1];
  assign rst_core_n = test_mode ? arst_n : core_sync_q;

  //////////////////////////////////////////////////////////////////////
  // Checks

  // Core domain never leaves reset before the always-on domain
  a_core_after_aon : assert property (
    @(posedge clk) rst_aon_n || !rst_core_n
  ) else $error("core reset released ahead of always-on reset");

endmodule

// File: cpu_irq_pkg.sv
// Interrupt definitions shared by the wake controller and the top.
// The four core interrupt lines travel together as one packed struct.

package cpu_irq_pkg;

  localparam int IRQ_LINES = 4;

  // Bit order from msb: debug, external, software, timer
  typedef struct packed {
    logic dbg;
    logic ext;
    logic sft;
    logic tmr;
  } irq_lines_t;

  localparam int IRQ_SYNC_STAGES = 2;

  //////////////////////////////////////////////////////////////////////
  // Wait-for-interrupt sleep state

  typedef enum logic {
    WAKE_RUN   = 1'b0,
    WAKE_SLEEP = 1'b1  // Core parked after wfi
  } wake_state_e;

endpackage

// File: cpu_clk_pkg.sv
// Clock and reset domain definitions for the always-on block.
// Covers the gated core units, the clock hold and reset sync depths,
// and the TCM light-sleep entry count.

package cpu_clk_pkg;

  //////////////////////////////////////////////////////////////////////
  // Gated core units

  localparam int NUM_UNITS = 4;

  // One bit per unit, indexed by unit_e
  typedef logic [NUM_UNITS-1:0] unit_vec_t;

  typedef enum logic [1:0] {
    UNIT_IFU = 2'd0,  // Instruction fetch
    UNIT_EXU = 2'd1,  // Execute
    UNIT_LSU = 2'd2,  // Load-store
    UNIT_BIU = 2'd3   // Bus interface
  } unit_e;

  //////////////////////////////////////////////////////////////////////
  // Clock gating and reset release

  localparam int CLK_HOLD_CYCLES = 4;  // Clock stays open after activity drops
  typedef logic [2:0] hold_cnt_t;

  localparam int RST_SYNC_STAGES = 2;

  //////////////////////////////////////////////////////////////////////
  // Memory light sleep

  localparam int LS_ENTRY_CYCLES = 8;  // Idle edges before sleep request
  typedef logic [3:0] ls_cnt_t;

endpackage
